/* corr_threshold.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_detect_config.svh"

module corr_threshold (
  input  wire                            clk,
  input  wire                            i_rst_n,
  input  wire                            i_clear,

  // sample stream in.
  input  wire                            i_valid,
  input  wire                            i_last,
  output logic                           o_ready,
  input  var pkt_detect_pkg::pd_sample_t i_sample,

  // gated stream out.
  output logic                           o_valid,
  output logic                           o_last,
  input  wire                            i_ready,
  output pkt_detect_pkg::pd_gated_t      o_gated
);

  import pkt_detect_pkg::*;

  pd_gated_t gated_d;
  logic      accept;

  // the threshold scales with signal power, so a weak channel needs less correlation.
  always_comb begin
    gated_d.sample = i_sample;
    gated_d.gate   = i_sample.corr > (i_sample.pow >> `PD_THRESH_SHIFT); // strictly above.
  end

  assign o_ready = (i_ready | ~o_valid) & i_rst_n;
  assign accept  = i_valid & o_ready;

  always_ff @(posedge clk) begin
    if (!i_rst_n || i_clear) begin
      o_valid <= 1'b0;
      o_last  <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
      o_last  <= i_valid & i_last;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      o_gated <= gated_d; // payload only moves with its sample.
    end
  end

  // the stage must come out of reset empty.
  a_empty_after_reset: assert property (
    @(posedge clk) $rose(i_rst_n) |-> !o_valid
  ) else $error("corr_threshold holds a sample right after reset.");

endmodule

`default_nettype wire

/* peak_report.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_detect_config.svh"

module peak_report (
  input  wire                            clk,
  input  wire                            i_rst_n,
  input  wire                            i_clear,

  // from the tracker.
  input  wire                            i_peak_stb,
  input  var pkt_detect_pkg::pd_report_t i_report,

  // held result for the host side.
  output logic                           o_report_valid,
  output pkt_detect_pkg::pd_report_t     o_report,
  output logic [`PD_NRX_WIDTH-1:0]       o_detect_count
);

  logic count_full;

  assign count_full = &o_detect_count;

  always_ff @(posedge clk) begin
    if (!i_rst_n || i_clear) begin
      o_report_valid <= 1'b0;
      o_detect_count <= '0;
    end else begin
      o_report_valid <= i_peak_stb; // one pulse per detection.
      if (i_peak_stb && !count_full) begin
        o_detect_count <= o_detect_count + 1'b1;
      end
    end
  end

  // keeps the last detection readable while the tracker hunts for the next one.
  always_ff @(posedge clk) begin
    if (i_peak_stb) begin
      o_report <= i_report;
    end
  end

  a_count_monotonic: assert property (
    @(posedge clk) disable iff (!i_rst_n)
      ($past(i_rst_n) && !$past(i_clear)) |-> (o_detect_count >= $past(o_detect_count))
  ) else $error("detection count went down without a clear.");

endmodule

`default_nettype wire

/* peak_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_detect_config.svh"

module peak_tracker (
  input  wire                           clk,
  input  wire                           i_rst_n,
  input  wire                           i_clear,

  // gated stream in.
  input  wire                           i_valid,
  input  wire                           i_last,
  output logic                          o_ready,
  input  var pkt_detect_pkg::pd_gated_t i_gated,

  // sample stream out, payload is dropped here.
  output logic                          o_valid,
  output logic                          o_last,
  input  wire                           i_ready,

  // confirmed peak to the result stage.
  output logic                          o_peak_stb,
  output pkt_detect_pkg::pd_report_t    o_report
);

  import pkt_detect_pkg::*;

  pd_state_t                 state;
  logic [`PD_NRX_WIDTH-1:0]  nrx_after_trig;  // gated samples since the run opened.
  logic [`PD_NRX_WIDTH-1:0]  nrx_after_peak;  // samples since the current maximum.
  logic [`PD_MIN_RISES-1:0]  rises;           // one bit per rise of the maximum.
  logic [`PD_DATA_WIDTH-1:0] max_corr;
  logic [`PD_DATA_WIDTH-1:0] max_pow;

  logic accept;
  logic new_max;
  logic confirm;

  assign o_ready = (i_ready | ~o_valid) & i_rst_n;
  assign accept  = i_valid & o_ready;
  assign new_max = i_gated.sample.corr > max_corr;

  // a peak counts only after a long enough run with a steadily climbing maximum.
  assign confirm = (nrx_after_trig >= `PD_NRX_WIDTH'(`PD_NRX_TRIG)) && (&rises);

  always_ff @(posedge clk) begin
    if (!i_rst_n || i_clear) begin
      state          <= ST_INIT;
      o_valid        <= 1'b0;
      o_last         <= 1'b0;
      o_peak_stb     <= 1'b0;
      nrx_after_trig <= '0;
      nrx_after_peak <= '0;
      rises          <= '0;
    end else begin
      o_peak_stb <= 1'b0;
      if (o_ready) begin
        o_valid <= i_valid;
        o_last  <= i_valid & i_last;
      end
      if (accept) begin
        case (state)
          ST_INIT: begin
            nrx_after_trig <= '0;
            nrx_after_peak <= '0;
            rises          <= '0;
            if (i_gated.gate) begin
              state <= ST_MAX;
            end
          end
          ST_MAX: begin
            if (i_gated.gate) begin
              nrx_after_trig <= nrx_after_trig + 1'b1;
              if (new_max) begin
                nrx_after_peak <= '0;
                rises          <= {rises[`PD_MIN_RISES-2:0], 1'b1};
              end else begin
                nrx_after_peak <= nrx_after_peak + 1'b1;
              end
            end else begin
              // the closing sample still counts toward the distance from the peak.
              nrx_after_peak <= nrx_after_peak + 1'b1;
              state          <= ST_TRIG;
            end
          end
          ST_TRIG: begin
            if (confirm) begin
              o_peak_stb <= 1'b1;
              state      <= ST_WAIT;
            end else begin
              state <= ST_INIT;
            end
          end
          default: begin
            state <= ST_INIT; // WAIT spends one sample before the next search.
          end
        endcase
      end
    end
  end

  // INIT takes every sample as the maximum and MAX only a strictly larger one.
  always_ff @(posedge clk) begin
    if (accept) begin
      if (state == ST_INIT || (state == ST_MAX && i_gated.gate && new_max)) begin
        max_corr <= i_gated.sample.corr;
        max_pow  <= i_gated.sample.pow;
      end
      if (state == ST_TRIG && confirm) begin
        o_report.nrx_after_peak <= nrx_after_peak;
        o_report.peak_pow       <= max_pow;
      end
    end
  end

  a_stb_single: assert property (
    @(posedge clk) disable iff (!i_rst_n) o_peak_stb |=> !o_peak_stb
  ) else $error("peak strobe held for more than one cycle.");

  a_state_legal: assert property (
    @(posedge clk) disable iff (!i_rst_n)
      !$isunknown(state) && (state inside {ST_INIT, ST_MAX, ST_TRIG, ST_WAIT})
  ) else $error("peak tracker left its four states.");

endmodule

`default_nettype wire

/* pkt_detect.f */
+incdir+.
pkt_detect_pkg.sv
corr_threshold.sv
peak_tracker.sv
peak_report.sv
pkt_detect_top.sv
tb_pkt_detect.sv

/* pkt_detect_config.svh */
`ifndef PKT_DETECT_CONFIG_SVH
`define PKT_DETECT_CONFIG_SVH

// width of the correlation and power words.
`define PD_DATA_WIDTH 16

// width of the sample counters in the tracker and the report.
`define PD_NRX_WIDTH 16

// gated samples needed after the first one before a peak can be confirmed.
`define PD_NRX_TRIG 64

// the gate opens when corr > (pow >> PD_THRESH_SHIFT).
`define PD_THRESH_SHIFT 2

// rises of the running maximum needed to confirm a peak.
`define PD_MIN_RISES 8

`endif

/* pkt_detect_pkg.sv */
`default_nettype none

`include "pkt_detect_config.svh"

package pkt_detect_pkg;

  // one sample from the correlator front end.
  typedef struct packed {
    logic [`PD_DATA_WIDTH-1:0] corr;
    logic [`PD_DATA_WIDTH-1:0] pow;
  } pd_sample_t;

  // sample after the decode stage, with its gate flag.
  typedef struct packed {
    pd_sample_t sample;
    logic       gate;
  } pd_gated_t;

  // a confirmed peak as handed to the result stage.
  typedef struct packed {
    logic [`PD_NRX_WIDTH-1:0]  nrx_after_peak;
    logic [`PD_DATA_WIDTH-1:0] peak_pow;
  } pd_report_t;

  // states of the peak tracker FSM.
  typedef enum logic [1:0] {
    ST_INIT = 2'b00,
    ST_MAX  = 2'b01,
    ST_WAIT = 2'b10,
    ST_TRIG = 2'b11
  } pd_state_t;

endpackage

`default_nettype wire

/* pkt_detect_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_detect_config.svh"

module pkt_detect_top (
  input  wire                            clk,
  input  wire                            i_rst_n,
  input  wire                            i_clear,

  // sample stream from the correlator.
  input  wire                            i_valid,
  input  wire                            i_last,
  output logic                           o_ready,
  input  var pkt_detect_pkg::pd_sample_t i_sample,

  // sample stream out.
  output logic                           o_valid,
  output logic                           o_last,
  input  wire                            i_out_ready,

  // detection results.
  output logic                           o_report_valid,
  output pkt_detect_pkg::pd_report_t     o_report,
  output logic [`PD_NRX_WIDTH-1:0]       o_detect_count
);

  import pkt_detect_pkg::*;

  pd_gated_t  gated;
  logic       dec_valid;
  logic       dec_last;
  logic       trk_ready;
  logic       peak_stb;
  pd_report_t trk_report;

  corr_threshold u_decode (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_clear  (i_clear),
    .i_valid  (i_valid),
    .i_last   (i_last),
    .o_ready  (o_ready),
    .i_sample (i_sample),
    .o_valid  (dec_valid),
    .o_last   (dec_last),
    .i_ready  (trk_ready),
    .o_gated  (gated)
  );

  peak_tracker u_execute (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_clear    (i_clear),
    .i_valid    (dec_valid),
    .i_last     (dec_last),
    .o_ready    (trk_ready),
    .i_gated    (gated),
    .o_valid    (o_valid),
    .o_last     (o_last),
    .i_ready    (i_out_ready),
    .o_peak_stb (peak_stb),
    .o_report   (trk_report)
  );

  peak_report u_result (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_clear        (i_clear),
    .i_peak_stb     (peak_stb),
    .i_report       (trk_report),
    .o_report_valid (o_report_valid),
    .o_report       (o_report),
    .o_detect_count (o_detect_count)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the packet detector testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module tb_pkt_detect -f pkt_detect.f \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_pkt_detect > sim.log 2>&1
cat sim.log

grep -q "TESTS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

/* tb_pkt_detect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_detect_config.svh"

module tb_pkt_detect;

  import pkt_detect_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int BURST_LEN  = 80;
  localparam int SHORT_LEN  = 40;
  localparam int TAIL       = 4;  // closing sample plus three fillers.
  localparam int TOTAL_SAMPLES = 6 * (BURST_LEN + TAIL) + 2 * (SHORT_LEN + TAIL) + SHORT_LEN;

  typedef struct packed {
    pd_report_t                rep;
    logic [`PD_NRX_WIDTH-1:0]  cnt;
  } exp_t;

  typedef enum int {M_INIT, M_MAX, M_TRIG, M_WAIT} model_state_t;

  logic                     clk = 1'b0;
  logic                     i_rst_n;
  logic                     i_clear;
  logic                     i_valid;
  logic                     i_last;
  logic                     o_ready;
  pd_sample_t               i_sample;
  logic                     o_valid;
  logic                     o_last;
  logic                     i_out_ready;
  logic                     o_report_valid;
  pd_report_t               o_report;
  logic [`PD_NRX_WIDTH-1:0] o_detect_count;

  // reference model of the gate and the tracker.
  model_state_t m_state = M_INIT;
  int           m_max;
  int           m_pow;
  int           m_trig;
  int           m_after;
  int           m_rises;
  int           m_count;
  exp_t         exp_q[$];
  logic         last_q[$];

  // copies of the DUT outputs taken just before each rising edge.
  logic                     seen_rv   = 1'b0;
  pd_report_t               seen_rep  = '0;
  logic [`PD_NRX_WIDTH-1:0] seen_cnt  = '0;
  logic                     seen_beat = 1'b0;
  logic                     seen_last = 1'b0;
  logic                     rep_ok    = 1'b0;
  logic                     beat_ok   = 1'b0;
  pd_report_t               exp_rep   = '0;
  logic                     exp_last  = 1'b0;
  logic [`PD_NRX_WIDTH-1:0] cnt_now   = '0;
  exp_t                     head;
  int                       sent  = 0;
  int                       beats = 0;

  logic [31:0] lfsr_state;
  bit          stall_on = 1'b0;
  bit          bp_on    = 1'b0;

  pkt_detect_top dut (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_clear        (i_clear),
    .i_valid        (i_valid),
    .i_last         (i_last),
    .o_ready        (o_ready),
    .i_sample       (i_sample),
    .o_valid        (o_valid),
    .o_last         (o_last),
    .i_out_ready    (i_out_ready),
    .o_report_valid (o_report_valid),
    .o_report       (o_report),
    .o_detect_count (o_detect_count)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_mismatch(input string msg);
    stop_run($sformatf("MISMATCH at %0t: %s", $time, msg));
  endtask

  // galois lfsr, one step per random bit.
  function automatic logic draw_bit();
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
    return lfsr_state[0];
  endfunction

  task automatic model_reset();
    m_state = M_INIT;
    m_count = 0;
    cnt_now = '0;
    exp_q.delete();
    last_q.delete();
  endtask

  task automatic model_step(input pd_sample_t s);
    int   corr;
    int   pow;
    bit   gate;
    exp_t e;
    corr = int'(s.corr);
    pow  = int'(s.pow);
    gate = corr > (pow >> `PD_THRESH_SHIFT);
    case (m_state)
      M_INIT: begin
        m_max   = corr;
        m_pow   = pow;
        m_trig  = 0;
        m_after = 0;
        m_rises = 0;
        if (gate) m_state = M_MAX;
      end
      M_MAX: begin
        if (gate) begin
          m_trig++;
          if (corr > m_max) begin
            m_max   = corr;
            m_pow   = pow;
            m_after = 0;
            m_rises++;
          end else begin
            m_after++;
          end
        end else begin
          m_after++; // the first ungated sample still counts.
          m_state = M_TRIG;
        end
      end
      M_TRIG: begin
        if (m_trig >= `PD_NRX_TRIG && m_rises >= `PD_MIN_RISES) begin
          m_count++;
          e.rep.nrx_after_peak = `PD_NRX_WIDTH'(m_after);
          e.rep.peak_pow       = `PD_DATA_WIDTH'(m_pow);
          e.cnt                = `PD_NRX_WIDTH'(m_count);
          exp_q.push_back(e);
          m_state = M_WAIT;
        end else begin
          m_state = M_INIT;
        end
      end
      default: m_state = M_INIT;
    endcase
  endtask

  // runs one ns before each rising edge, when inputs and outputs are settled.
  always @(negedge clk) begin
    #(CLK_PERIOD / 2 - 1);
    seen_rv   = o_report_valid;
    seen_rep  = o_report;
    seen_cnt  = o_detect_count;
    seen_beat = o_valid && i_out_ready;
    seen_last = o_last;
    if (!i_rst_n || i_clear) begin
      model_reset();
    end else begin
      if (seen_rv) begin
        rep_ok = exp_q.size() != 0;
        if (rep_ok) begin
          head    = exp_q.pop_front();
          exp_rep = head.rep;
          cnt_now = head.cnt;
        end
      end
      if (seen_beat) begin
        beat_ok = last_q.size() != 0;
        if (beat_ok) exp_last = last_q.pop_front();
        beats++;
      end
      if (i_valid && o_ready) begin
        last_q.push_back(i_last);
        sent++;
        model_step(i_sample);
      end
    end
  end

  a_report_match: assert property (
    @(posedge clk) disable iff (!i_rst_n || i_clear) seen_rv |-> (rep_ok && seen_rep == exp_rep)
  ) else report_mismatch($sformatf("report nrx %0d pow %0d, expected %0d %0d (expected: %0b)",
    seen_rep.nrx_after_peak, seen_rep.peak_pow, exp_rep.nrx_after_peak, exp_rep.peak_pow, rep_ok));

  a_count_match: assert property (
    @(posedge clk) disable iff (!i_rst_n || i_clear) seen_cnt == cnt_now
  ) else report_mismatch($sformatf("detection count %0d, expected %0d", seen_cnt, cnt_now));

  a_beat_match: assert property (
    @(posedge clk) disable iff (!i_rst_n || i_clear) seen_beat |-> (beat_ok && seen_last == exp_last)
  ) else report_mismatch($sformatf("output beat last %0b, expected %0b (sample pending: %0b)",
    seen_last, exp_last, beat_ok));

  task automatic next_cycle();
    logic b0;
    logic b1;
    @(negedge clk);
    if (bp_on) begin
      b0 = draw_bit();
      b1 = draw_bit();
      i_out_ready = b0 | b1;
    end else begin
      i_out_ready = 1'b1;
    end
  endtask

  task automatic send_sample(input int corr, input int pow, input logic last);
    logic b0;
    logic b1;
    b0 = 1'b0;
    b1 = 1'b0;
    if (stall_on) begin
      b0 = draw_bit();
      b1 = draw_bit();
    end
    while (b0 & b1) begin
      next_cycle();
      i_valid = 1'b0;
      b0 = draw_bit();
      b1 = draw_bit();
    end
    next_cycle();
    i_valid       = 1'b1;
    i_last        = last;
    i_sample.corr = `PD_DATA_WIDTH'(corr);
    i_sample.pow  = `PD_DATA_WIDTH'(pow);
    #1;
    while (!o_ready) begin
      next_cycle();
      #1;
    end
  endtask

  // first sample opens the run, the next n_rises climb, the rest sit below the peak.
  task automatic send_burst(input int n_gated, input int n_rises, input bit at_edge,
                            input bit with_tail);
    int corr;
    int pow;
    for (int i = 0; i < n_gated; i++) begin
      corr = (i <= n_rises) ? 300 + 100 * i : 350;
      pow  = (i == n_rises) ? 1200 : 1000;
      if (at_edge) pow = corr * 4; // exactly on the threshold.
      send_sample(corr, pow, 1'b0);
    end
    if (with_tail) begin
      send_sample(100, 1000, 1'b0);
      for (int i = 0; i < TAIL - 2; i++) send_sample(50, 1000, 1'b0);
      send_sample(50, 1000, 1'b1);
    end
  endtask

  task automatic drain();
    next_cycle();
    i_valid = 1'b0;
    i_last  = 1'b0;
    while (last_q.size() != 0) next_cycle();
    repeat (2) next_cycle();
    assert (exp_q.size() == 0) else report_mismatch("a predicted report never appeared");
  endtask

  task automatic check_count(input int n);
    assert (o_detect_count == `PD_NRX_WIDTH'(n))
      else report_mismatch($sformatf("detection count %0d, expected %0d", o_detect_count, n));
  endtask

  initial begin
    #(CLK_PERIOD * (TOTAL_SAMPLES * 4 + 200));
    stop_run("ERROR: the watchdog expired before the tests finished.");
  end

  initial begin
    $timeformat(-9, 1, " ns", 0);
    lfsr_state  = 32'h8029f004;
    i_rst_n     = 1'b0;
    i_clear     = 1'b0;
    i_valid     = 1'b0;
    i_last      = 1'b0;
    i_sample    = '0;
    i_out_ready = 1'b1;
    repeat (5) @(negedge clk);
    i_rst_n = 1'b1;

    send_burst(BURST_LEN, 10, 1'b0, 1'b1); // confirmed burst.
    drain();
    check_count(1);
    send_burst(SHORT_LEN, 10, 1'b0, 1'b1);
    drain();
    check_count(1);
    send_burst(BURST_LEN, 5, 1'b0, 1'b1);
    drain();
    check_count(1);
    send_burst(BURST_LEN, 10, 1'b1, 1'b1);
    drain();
    check_count(1);

    stall_on = 1'b1;
    bp_on    = 1'b1;
    send_burst(BURST_LEN, 10, 1'b0, 1'b1);
    send_burst(SHORT_LEN, 10, 1'b0, 1'b1);
    send_burst(BURST_LEN, 9, 1'b0, 1'b1);
    drain();
    stall_on = 1'b0;
    bp_on    = 1'b0;
    check_count(3);

    // a clear in the middle of a run drops it.
    send_burst(SHORT_LEN, 10, 1'b0, 1'b0);
    drain();
    next_cycle();
    i_clear = 1'b1;
    next_cycle();
    i_clear = 1'b0;
    check_count(0);
    send_burst(BURST_LEN, 10, 1'b0, 1'b1);
    drain();
    check_count(1);

    if (beats != sent || exp_q.size() != 0) begin
      report_mismatch($sformatf("%0d beats out for %0d samples in", beats, sent));
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
